//--- src.f
+incdir+tb
verilog/tcdm_pkg.sv
verilog/dma_addr_decoder.sv
verilog/core_bank_router.sv
verilog/tcdm_superbank.sv
verilog/tcdm_subsystem.sv
tb/tb_tcdm_subsystem.sv

//--- tb/tb_tcdm_model.svh
/*
 * reference memory model for the TCDM testbench
 * byte array over the 4 kiB map, masked stores, expected line and word for loads
 */
`ifndef TB_TCDM_MODEL_SVH
`define TB_TCDM_MODEL_SVH

  logic [7:0] model_mem [NR_SUPERBANKS*NR_LINES*DMA_BE_W];   // indexed by addr[11:0]

  // line wide store, byte offset bits dropped
  function automatic void store_line(input logic [DMA_ADDR_W-1:0] addr,
                                     input logic [DMA_DATA_W-1:0] data,
                                     input logic [DMA_BE_W-1:0]   be);
    for (int b = 0; b < DMA_BE_W; b++) begin
      if (be[b]) model_mem[{addr[11:4], 4'h0} + b] = data[b*8 +: 8];
    end
  endfunction

  // core word store, bytes follow the word address
  function automatic void store_word(input logic [DMA_ADDR_W-1:0]  addr,
                                     input logic [CORE_DATA_W-1:0] data,
                                     input logic [CORE_BE_W-1:0]   be);
    for (int b = 0; b < CORE_BE_W; b++) begin
      if (be[b]) model_mem[{addr[11:2], 2'b00} + b] = data[b*8 +: 8];
    end
  endfunction

  function automatic logic [DMA_DATA_W-1:0] expect_line(input logic [DMA_ADDR_W-1:0] addr);
    logic [DMA_DATA_W-1:0] line;
    for (int b = 0; b < DMA_BE_W; b++) begin
      line[b*8 +: 8] = model_mem[{addr[11:4], 4'h0} + b];   // byte 0 at the lsb
    end
    return line;
  endfunction

  function automatic logic [CORE_DATA_W-1:0] expect_word(input logic [DMA_ADDR_W-1:0] addr);
    logic [CORE_DATA_W-1:0] word;
    for (int b = 0; b < CORE_BE_W; b++) begin
      word[b*8 +: 8] = model_mem[{addr[11:2], 2'b00} + b];
    end
    return word;
  endfunction

`endif

//--- tb/tb_tcdm_subsystem.sv
/*
 * TCDM subsystem testbench with directed and random dma and core traffic
 * grant monitor feeding the memory model, read data compare and a watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_tcdm_subsystem import tcdm_pkg::*; ();

  logic                   clk_i;
  logic                   rst_i;
  logic                   dma_req_i;
  logic [DMA_ADDR_W-1:0]  dma_addr_i;
  mem_op_e                dma_op_i;
  logic [DMA_DATA_W-1:0]  dma_wdata_i;
  logic [DMA_BE_W-1:0]    dma_be_i;
  logic                   dma_gnt_o;
  logic [DMA_DATA_W-1:0]  dma_rdata_o;
  logic                   core_req_i;
  logic [DMA_ADDR_W-1:0]  core_addr_i;
  mem_op_e                core_op_i;
  logic [CORE_DATA_W-1:0] core_wdata_i;
  logic [CORE_BE_W-1:0]   core_be_i;
  logic                   core_gnt_o;
  logic [CORE_DATA_W-1:0] core_rdata_o;

  int unsigned cyc = 0;        // rising edges seen
  int unsigned n_issued = 0;   // sets the watchdog limit
  int unsigned n_loads = 0;    // loads issued by the stimulus
  int unsigned n_checked = 0;
  int          seed;

  // pending loads per port in issue order
  int unsigned            dma_due[$];
  logic [DMA_DATA_W-1:0]  dma_exp[$];
  int unsigned            core_due[$];
  logic [CORE_DATA_W-1:0] core_exp[$];

  // random traffic drawn up front
  mem_op_e                r_dma_op    [64];
  logic [DMA_ADDR_W-1:0]  r_dma_addr  [64];
  logic [DMA_DATA_W-1:0]  r_dma_data  [64];
  logic [DMA_BE_W-1:0]    r_dma_be    [64];
  mem_op_e                r_core_op   [64];
  logic [DMA_ADDR_W-1:0]  r_core_addr [64];
  logic [CORE_DATA_W-1:0] r_core_data [64];
  logic [CORE_BE_W-1:0]   r_core_be   [64];

  `include "tb_tcdm_model.svh"

  tcdm_subsystem uut (.*);

  always #10 clk_i = ~clk_i;

  // byte address from superbank, line and lane
  function automatic logic [DMA_ADDR_W-1:0] tcdm_addr(input int sb, input int line,
                                                      input int lane);
    return (line << (LINE_OFF_W + SB_W)) | (sb << LINE_OFF_W) | (lane << 2);
  endfunction

  // preload pattern where every byte depends on all twelve address bits
  function automatic logic [DMA_DATA_W-1:0] fill_line(input logic [11:0] base);
    logic [DMA_DATA_W-1:0] line;
    logic [11:0]           a;
    for (int b = 0; b < DMA_BE_W; b++) begin
      a = base + b;
      line[b*8 +: 8] = a[7:0] ^ {a[11:8], ~a[11:8]};
    end
    return line;
  endfunction

  task automatic report_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // called 2 ns after an edge and returns 2 ns after the granting edge
  task automatic dma_access(input mem_op_e op, input logic [DMA_ADDR_W-1:0] addr,
                            input logic [DMA_DATA_W-1:0] wdata, input logic [DMA_BE_W-1:0] be);
    dma_req_i   = 1'b1;
    dma_op_i    = op;
    dma_addr_i  = addr;
    dma_wdata_i = wdata;
    dma_be_i    = be;
    n_issued++;
    if (op == op_load) n_loads++;
    @(posedge clk_i);
    while (!dma_gnt_o) @(posedge clk_i);   // payload held while stalled
    #2;
    dma_req_i = 1'b0;
  endtask

  task automatic core_access(input mem_op_e op, input logic [DMA_ADDR_W-1:0] addr,
                             input logic [CORE_DATA_W-1:0] wdata, input logic [CORE_BE_W-1:0] be);
    core_req_i   = 1'b1;
    core_op_i    = op;
    core_addr_i  = addr;
    core_wdata_i = wdata;
    core_be_i    = be;
    n_issued++;
    if (op == op_load) n_loads++;
    @(posedge clk_i);
    while (!core_gnt_o) @(posedge clk_i);
    #2;
    core_req_i = 1'b0;
  endtask

  // model follows every granting edge
  always @(posedge clk_i) begin
    cyc++;
    if (cyc > 4 * n_issued + 200) begin
      $display("timeout after %0d cycles, %0d requests issued", cyc, n_issued);
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
    end else begin
      if (dma_req_i && dma_gnt_o) begin
        if (dma_op_i == op_store) begin
          store_line(dma_addr_i, dma_wdata_i, dma_be_i);
        end else begin
          dma_exp.push_back(expect_line(dma_addr_i));
          dma_due.push_back(cyc + MEM_LATENCY - 1);   // read data out after that edge
        end
      end
      if (core_req_i && core_gnt_o) begin
        if (core_op_i == op_store) begin
          store_word(core_addr_i, core_wdata_i, core_be_i);
        end else begin
          core_exp.push_back(expect_word(core_addr_i));
          core_due.push_back(cyc + MEM_LATENCY - 1);
        end
      end
    end
  end

  // compare at the falling edge where read data is settled
  always @(negedge clk_i) begin
    logic [DMA_DATA_W-1:0]  exp_line;
    logic [CORE_DATA_W-1:0] exp_word;
    if (dma_due.size() != 0 && dma_due[0] == cyc) begin
      void'(dma_due.pop_front());
      exp_line = dma_exp.pop_front();
      n_checked++;
      assert (dma_rdata_o === exp_line)
        else report_error($sformatf("dma load expected %h got %h", exp_line, dma_rdata_o));
    end
    if (core_due.size() != 0 && core_due[0] == cyc) begin
      void'(core_due.pop_front());
      exp_word = core_exp.pop_front();
      n_checked++;
      assert (core_rdata_o === exp_word)
        else report_error($sformatf("core load expected %h got %h", exp_word, core_rdata_o));
    end
  end

  initial begin
    logic [DMA_ADDR_W-1:0] a;
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    dma_req_i    = 1'b0;
    dma_addr_i   = '0;
    dma_op_i     = op_load;
    dma_wdata_i  = '0;
    dma_be_i     = '0;
    core_req_i   = 1'b0;
    core_addr_i  = '0;
    core_op_i    = op_load;
    core_wdata_i = '0;
    core_be_i    = '0;
    seed         = 32'h645b_c39d;
    for (int i = 0; i < $size(r_dma_op); i++) begin
      r_dma_op[i]    = ($random(seed) & 1) ? op_store : op_load;
      r_dma_addr[i]  = $random(seed);                  // upper bits ignored by the map
      r_dma_data[i]  = {$random(seed), $random(seed), $random(seed), $random(seed)};
      r_dma_be[i]    = $random(seed);
      r_core_op[i]   = ($random(seed) & 1) ? op_store : op_load;
      r_core_addr[i] = $random(seed) & ~32'h3;         // word aligned only
      r_core_data[i] = $random(seed);
      r_core_be[i]   = $random(seed);
    end
    repeat (10) @(posedge clk_i);
    #2;
    rst_i = 1'b0;

    // preload the whole array so no load sees an unwritten line
    for (int i = 0; i < NR_SUPERBANKS * NR_LINES; i++) begin
      dma_access(op_store, i * DMA_BE_W, fill_line(i * DMA_BE_W), '1);
    end
    // distinct lines in every superbank with high address bits set
    for (int sb = 0; sb < NR_SUPERBANKS; sb++) begin
      a = 32'ha000_0000 | tcdm_addr(sb, sb + 3, 0);
      dma_access(op_store, a, {a, ~a, a ^ 32'h5a5a_5a5a, 32'(sb)}, '1);
    end
    for (int i = 0; i < NR_SUPERBANKS * NR_LINES; i++) begin
      dma_access(op_load, i * DMA_BE_W, '0, '0);        // back to back line reads
    end

    // sparse byte enables keep the old bytes
    a = tcdm_addr(2, 17, 0);
    dma_access(op_store, a, {4{32'hdead_beef}}, '1);
    dma_access(op_store, a, {16{8'h11}}, 16'h8421);
    dma_access(op_store, a, {16{8'h7e}}, 16'h0300);
    dma_access(op_load, a, '0, '0);

    // core lanes read as one line and a dma line read by lanes
    for (int lane = 0; lane < LANES; lane++) begin
      core_access(op_store, tcdm_addr(1, 40, lane), 32'hc0de_0000 + lane, '1);
    end
    core_access(op_store, tcdm_addr(1, 40, 2), 32'hffff_ffff, 4'b0101);
    dma_access(op_load, tcdm_addr(1, 40, 0), '0, '0);
    dma_access(op_store, tcdm_addr(3, 9, 0), {32'h4444_4444, 32'h3333_3333,
                                               32'h2222_2222, 32'h1111_1111}, '1);
    for (int lane = 0; lane < LANES; lane++) begin
      core_access(op_load, tcdm_addr(3, 9, lane), '0, '0);
    end

    // same superbank from both ports where the core wins
    fork
      begin
        core_access(op_load, tcdm_addr(0, 5, 1), '0, '0);
        core_access(op_store, tcdm_addr(0, 6, 3), 32'h600d_cafe, '1);
      end
      dma_access(op_store, tcdm_addr(0, 5, 0), {4{32'h0bad_f00d}}, '1);
      begin
        @(posedge clk_i);
        assert (core_gnt_o === 1'b1 && dma_gnt_o === 1'b0)
          else report_error("dma granted while core holds the same superbank");
      end
    join
    dma_access(op_load, tcdm_addr(0, 5, 0), '0, '0);
    core_access(op_load, tcdm_addr(0, 5, 1), '0, '0);

    // random mixed traffic on both ports at once
    fork
      for (int i = 0; i < $size(r_dma_op); i++) begin
        dma_access(r_dma_op[i], r_dma_addr[i], r_dma_data[i], r_dma_be[i]);
      end
      for (int i = 0; i < $size(r_core_op); i++) begin
        core_access(r_core_op[i], r_core_addr[i], r_core_data[i], r_core_be[i]);
      end
    join

    while (dma_due.size() != 0 || core_due.size() != 0) @(posedge clk_i);
    @(posedge clk_i);
    if (n_checked == n_loads) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("only %0d of %0d loads were compared", n_checked, n_loads);
      $display("TEST FAILED");
      $fatal(1, "missing read data checks");
    end
  end

endmodule : tb_tcdm_subsystem

`default_nettype wire

//--- verilog/tcdm_subsystem.sv
/*
 * TCDM top level: dma decoder and core router
 * in front of NR_SUPERBANKS superbanks
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_subsystem import tcdm_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,

  // wide dma port
  input  logic                   dma_req_i,
  input  logic [DMA_ADDR_W-1:0]  dma_addr_i,
  input  mem_op_e                dma_op_i,
  input  logic [DMA_DATA_W-1:0]  dma_wdata_i,
  input  logic [DMA_BE_W-1:0]    dma_be_i,
  output logic                   dma_gnt_o,
  output logic [DMA_DATA_W-1:0]  dma_rdata_o,

  // narrow core port
  input  logic                   core_req_i,
  input  logic [DMA_ADDR_W-1:0]  core_addr_i,
  input  mem_op_e                core_op_i,
  input  logic [CORE_DATA_W-1:0] core_wdata_i,
  input  logic [CORE_BE_W-1:0]   core_be_i,
  output logic                   core_gnt_o,
  output logic [CORE_DATA_W-1:0] core_rdata_o
);

  // dma side vectors
  logic    [NR_SUPERBANKS-1:0]                  dma_sb_req;
  logic    [NR_SUPERBANKS-1:0][TCDM_ADDR_W-1:0] dma_sb_line;
  mem_op_e [NR_SUPERBANKS-1:0]                  dma_sb_op;
  logic    [NR_SUPERBANKS-1:0][DMA_DATA_W-1:0]  dma_sb_wdata;
  logic    [NR_SUPERBANKS-1:0][DMA_BE_W-1:0]    dma_sb_be;
  logic    [NR_SUPERBANKS-1:0]                  dma_sb_gnt;

  // core side vectors
  logic    [NR_SUPERBANKS-1:0]                  core_sb_req;
  logic    [NR_SUPERBANKS-1:0][TCDM_ADDR_W-1:0] core_sb_line;
  mem_op_e [NR_SUPERBANKS-1:0]                  core_sb_op;
  logic    [NR_SUPERBANKS-1:0][DMA_DATA_W-1:0]  core_sb_wdata;
  logic    [NR_SUPERBANKS-1:0][DMA_BE_W-1:0]    core_sb_be;
  logic    [NR_SUPERBANKS-1:0]                  core_sb_gnt;

  logic    [NR_SUPERBANKS-1:0][DMA_DATA_W-1:0]  sb_rdata;   // goes to both routers

  dma_addr_decoder u_dma_dec (
    .clk_i, .rst_i,
    .dma_req_i, .dma_addr_i, .dma_op_i, .dma_wdata_i, .dma_be_i,
    .dma_gnt_o, .dma_rdata_o,
    .sb_req_o   (dma_sb_req),   .sb_line_o (dma_sb_line), .sb_op_o (dma_sb_op),
    .sb_wdata_o (dma_sb_wdata), .sb_be_o   (dma_sb_be),
    .sb_gnt_i   (dma_sb_gnt),   .sb_rdata_i(sb_rdata)
  );

  core_bank_router u_core_rt (
    .clk_i, .rst_i,
    .core_req_i, .core_addr_i, .core_op_i, .core_wdata_i, .core_be_i,
    .core_gnt_o, .core_rdata_o,
    .sb_req_o   (core_sb_req),   .sb_line_o (core_sb_line), .sb_op_o (core_sb_op),
    .sb_wdata_o (core_sb_wdata), .sb_be_o   (core_sb_be),
    .sb_gnt_i   (core_sb_gnt),   .sb_rdata_i(sb_rdata)
  );

  for (genvar g = 0; g < NR_SUPERBANKS; g++) begin : u_sb
    tcdm_superbank u_bank (
      .clk_i, .rst_i,
      .core_req_i (core_sb_req[g]),  .core_line_i(core_sb_line[g]), .core_op_i(core_sb_op[g]),
      .core_wdata_i(core_sb_wdata[g]), .core_be_i(core_sb_be[g]),  .core_gnt_o(core_sb_gnt[g]),
      .dma_req_i  (dma_sb_req[g]),   .dma_line_i (dma_sb_line[g]),  .dma_op_i (dma_sb_op[g]),
      .dma_wdata_i(dma_sb_wdata[g]), .dma_be_i   (dma_sb_be[g]),    .dma_gnt_o(dma_sb_gnt[g]),
      .rdata_o    (sb_rdata[g])
    );
  end

endmodule : tcdm_subsystem

`default_nettype wire

//--- verilog/tcdm_superbank.sv
/*
 * one TCDM superbank: fixed core-over-dma arbitration,
 * line wide byte enabled array and a read latency pipeline
 */
`timescale 1ns/1ps
`default_nettype none

module tcdm_superbank import tcdm_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,

  // core side, already line wide
  input  logic                   core_req_i,
  input  logic [TCDM_ADDR_W-1:0] core_line_i,
  input  mem_op_e                core_op_i,
  input  logic [DMA_DATA_W-1:0]  core_wdata_i,
  input  logic [DMA_BE_W-1:0]    core_be_i,
  output logic                   core_gnt_o,

  // dma side
  input  logic                   dma_req_i,
  input  logic [TCDM_ADDR_W-1:0] dma_line_i,
  input  mem_op_e                dma_op_i,
  input  logic [DMA_DATA_W-1:0]  dma_wdata_i,
  input  logic [DMA_BE_W-1:0]    dma_be_i,
  output logic                   dma_gnt_o,

  output logic [DMA_DATA_W-1:0]  rdata_o      // shared by both routers
);

  owner_e                 owner;
  logic [TCDM_ADDR_W-1:0] sel_line;
  mem_op_e                sel_op;
  logic [DMA_DATA_W-1:0]  sel_wdata;
  logic [DMA_BE_W-1:0]    sel_be;
  logic                   wr_en;
  logic                   rd_en;

  logic [DMA_DATA_W-1:0] mem [NR_LINES];                 // the array, no reset
  logic [MEM_LATENCY-1:0][DMA_DATA_W-1:0] rd_q;          // read pipe

  // core always wins, dma only on a free cycle
  always_comb begin
    if (core_req_i) begin
      owner = owner_core;
    end else if (dma_req_i) begin
      owner = owner_dma;
    end else begin
      owner = owner_none;
    end
  end

  assign core_gnt_o = (owner == owner_core);
  assign dma_gnt_o  = (owner == owner_dma);

  // winner's payload, dma fields when idle (masked by wr_en/rd_en)
  assign sel_line  = (owner == owner_core) ? core_line_i  : dma_line_i;
  assign sel_op    = (owner == owner_core) ? core_op_i    : dma_op_i;
  assign sel_wdata = (owner == owner_core) ? core_wdata_i : dma_wdata_i;
  assign sel_be    = (owner == owner_core) ? core_be_i    : dma_be_i;

  assign wr_en = (owner != owner_none) && (sel_op == op_store);
  assign rd_en = (owner != owner_none) && (sel_op == op_load);

  // byte masked store at the granting edge
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < DMA_BE_W; b++) begin
        if (sel_be[b]) mem[sel_line][b*8 +: 8] <= sel_wdata[b*8 +: 8];
      end
    end
  end

  // stage 0 captures the line, later stages just shift
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_q <= '0;
    end else begin
      if (rd_en) rd_q[0] <= mem[sel_line];
      for (int i = 1; i < MEM_LATENCY; i++) begin
        rd_q[i] <= rd_q[i-1];
      end
    end
  end

  assign rdata_o = rd_q[MEM_LATENCY-1];   // valid MEM_LATENCY edges after a read grant

  // exclusive grant
  a_gnt_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(core_gnt_o && dma_gnt_o));

  // owner only with a matching request, dma only when core is idle
  a_owner_req: assert property (@(posedge clk_i) disable iff (rst_i)
    (owner == owner_core |-> core_req_i) and
    (owner == owner_dma  |-> dma_req_i && !core_req_i));

endmodule : tcdm_superbank

`default_nettype wire

//--- verilog/core_bank_router.sv
/*
 * core bank router: decodes superbank, line and lane of a 32-bit access,
 * places word and byte enables in the line, returns the delayed lane
 */
`timescale 1ns/1ps
`default_nettype none

module core_bank_router import tcdm_pkg::*; (
  input  logic                                        clk_i,
  input  logic                                        rst_i,

  // core master side
  input  logic                                        core_req_i,
  input  logic    [DMA_ADDR_W-1:0]                    core_addr_i,
  input  mem_op_e                                     core_op_i,
  input  logic    [CORE_DATA_W-1:0]                   core_wdata_i,
  input  logic    [CORE_BE_W-1:0]                     core_be_i,
  output logic                                        core_gnt_o,
  output logic    [CORE_DATA_W-1:0]                   core_rdata_o,

  // superbank side, always line wide
  output logic    [NR_SUPERBANKS-1:0]                 sb_req_o,
  output logic    [NR_SUPERBANKS-1:0][TCDM_ADDR_W-1:0] sb_line_o,
  output mem_op_e [NR_SUPERBANKS-1:0]                 sb_op_o,
  output logic    [NR_SUPERBANKS-1:0][DMA_DATA_W-1:0] sb_wdata_o,
  output logic    [NR_SUPERBANKS-1:0][DMA_BE_W-1:0]   sb_be_o,
  input  logic    [NR_SUPERBANKS-1:0]                 sb_gnt_i,
  input  logic    [NR_SUPERBANKS-1:0][DMA_DATA_W-1:0] sb_rdata_i
);

  logic [SB_W-1:0]        super_bank;
  logic [TCDM_ADDR_W-1:0] line_addr;
  logic [LANE_W-1:0]      lane;         // word within the line
  logic [DMA_BE_W-1:0]    lane_be;      // byte enables moved to the lane

  // superbank and lane history for the read return
  logic [MEM_LATENCY-1:0][SB_W-1:0]   sb_q;
  logic [MEM_LATENCY-1:0][LANE_W-1:0] lane_q;

  assign super_bank = core_addr_i[LINE_OFF_W +: SB_W];
  assign line_addr  = core_addr_i[LINE_OFF_W + SB_W +: TCDM_ADDR_W];
  assign lane       = core_addr_i[LINE_OFF_W-1 -: LANE_W];   // bits 3..2
  assign lane_be    = {{(DMA_BE_W-CORE_BE_W){1'b0}}, core_be_i} << (lane * CORE_BE_W);

  always_comb begin
    sb_req_o   = '0;
    sb_line_o  = '0;
    sb_op_o    = {NR_SUPERBANKS{op_load}};
    sb_wdata_o = '0;
    sb_be_o    = '0;

    sb_req_o[super_bank]   = core_req_i;
    sb_line_o[super_bank]  = line_addr;
    sb_op_o[super_bank]    = core_op_i;
    sb_wdata_o[super_bank] = {LANES{core_wdata_i}};  // word copied to every lane
    sb_be_o[super_bank]    = lane_be;                // only one lane written

    core_gnt_o   = sb_gnt_i[super_bank];
    // slice the returned line at the lane of that earlier request
    core_rdata_o = sb_rdata_i[sb_q[MEM_LATENCY-1]][lane_q[MEM_LATENCY-1]*CORE_DATA_W +: CORE_DATA_W];
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sb_q   <= '0;
      lane_q <= '0;
    end else begin
      sb_q[0]   <= super_bank;
      lane_q[0] <= lane;
      for (int i = 1; i < MEM_LATENCY; i++) begin
        sb_q[i]   <= sb_q[i-1];
        lane_q[i] <= lane_q[i-1];
      end
    end
  end

  // single superbank lane, and only while the core requests
  a_sb_req_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(sb_req_o) && ((|sb_req_o) == core_req_i));

endmodule : core_bank_router

`default_nettype wire

//--- verilog/dma_addr_decoder.sv
/*
 * dma address decoder: steers one wide request to a single superbank,
 * returns the grant combinationally and picks the delayed read line
 */
`timescale 1ns/1ps
`default_nettype none

module dma_addr_decoder import tcdm_pkg::*; (
  input  logic                                        clk_i,
  input  logic                                        rst_i,

  // dma master side
  input  logic                                        dma_req_i,
  input  logic    [DMA_ADDR_W-1:0]                    dma_addr_i,  // byte address
  input  mem_op_e                                     dma_op_i,
  input  logic    [DMA_DATA_W-1:0]                    dma_wdata_i,
  input  logic    [DMA_BE_W-1:0]                      dma_be_i,
  output logic                                        dma_gnt_o,
  output logic    [DMA_DATA_W-1:0]                    dma_rdata_o,

  // superbank side, one lane per superbank
  output logic    [NR_SUPERBANKS-1:0]                 sb_req_o,
  output logic    [NR_SUPERBANKS-1:0][TCDM_ADDR_W-1:0] sb_line_o,
  output mem_op_e [NR_SUPERBANKS-1:0]                 sb_op_o,
  output logic    [NR_SUPERBANKS-1:0][DMA_DATA_W-1:0] sb_wdata_o,
  output logic    [NR_SUPERBANKS-1:0][DMA_BE_W-1:0]   sb_be_o,
  input  logic    [NR_SUPERBANKS-1:0]                 sb_gnt_i,
  input  logic    [NR_SUPERBANKS-1:0][DMA_DATA_W-1:0] sb_rdata_i
);

  logic [SB_W-1:0]        super_bank;   // addressed superbank
  logic [TCDM_ADDR_W-1:0] line_addr;    // line inside it

  // superbank index per cycle, oldest entry routes rdata
  logic [MEM_LATENCY-1:0][SB_W-1:0] sb_q;

  // address split, upper bits dropped
  assign super_bank = dma_addr_i[LINE_OFF_W +: SB_W];
  assign line_addr  = dma_addr_i[LINE_OFF_W + SB_W +: TCDM_ADDR_W];

  always_comb begin
    // idle lanes stay zero
    sb_req_o   = '0;
    sb_line_o  = '0;
    sb_op_o    = {NR_SUPERBANKS{op_load}};
    sb_wdata_o = '0;
    sb_be_o    = '0;

    // forward mux to the addressed superbank
    sb_req_o[super_bank]   = dma_req_i;
    sb_line_o[super_bank]  = line_addr;
    sb_op_o[super_bank]    = dma_op_i;
    sb_wdata_o[super_bank] = dma_wdata_i;
    sb_be_o[super_bank]    = dma_be_i;

    dma_gnt_o   = sb_gnt_i[super_bank];              // same cycle grant
    dma_rdata_o = sb_rdata_i[sb_q[MEM_LATENCY-1]];   // line from MEM_LATENCY edges back
  end

  // index chain shifts every cycle, matches the superbank read pipe
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sb_q <= '0;
    end else begin
      sb_q[0] <= super_bank;
      for (int i = 1; i < MEM_LATENCY; i++) begin
        sb_q[i] <= sb_q[i-1];
      end
    end
  end

  // never more than one superbank addressed
  a_sb_req_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(sb_req_o));

  // a stalled dma request keeps its payload until granted
  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    dma_req_i && !dma_gnt_o |=> dma_req_i && $stable(dma_addr_i) && $stable(dma_op_i)
      && $stable(dma_wdata_i) && $stable(dma_be_i));

endmodule : dma_addr_decoder

`default_nettype wire

//--- verilog/tcdm_pkg.sv
/*
 * shared address map, widths and latency of the two-master TCDM
 * memory operation and arbitration owner enums
 */
`default_nettype none

package tcdm_pkg;

  // line and port widths
  localparam int unsigned DMA_DATA_W    = 128;             // one full superbank line
  localparam int unsigned DMA_BE_W      = DMA_DATA_W / 8;
  localparam int unsigned DMA_ADDR_W    = 32;              // byte address, dma and core
  localparam int unsigned CORE_DATA_W   = 32;
  localparam int unsigned CORE_BE_W     = CORE_DATA_W / 8;

  // address map: [3:0] byte in line, [5:4] superbank, [11:6] line, rest ignored
  localparam int unsigned NR_SUPERBANKS = 4;
  localparam int unsigned SB_W          = 2;               // log2 of NR_SUPERBANKS
  localparam int unsigned LINE_OFF_W    = 4;               // log2 of DMA_BE_W
  localparam int unsigned TCDM_ADDR_W   = 6;
  localparam int unsigned NR_LINES      = 2 ** TCDM_ADDR_W; // lines per superbank

  // core words inside a line, lane sits at the top of the line offset
  localparam int unsigned LANES         = DMA_DATA_W / CORE_DATA_W;
  localparam int unsigned LANE_W        = 2;

  // granting edge to valid read data
  localparam int unsigned MEM_LATENCY   = 2;

  // memory operation, replaces a raw write enable
  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } mem_op_e;

  // who won the superbank this cycle
  typedef enum logic [1:0] {
    owner_none = 2'd0,
    owner_core = 2'd1,
    owner_dma  = 2'd2
  } owner_e;

endpackage : tcdm_pkg

`default_nettype wire
